//--- Bender.yml
package:
  name: soc_debug

sources:
  - files:
      - source/soc_pkg.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/dbg_bridge.sv
      - source/switch_logger.sv
      - source/mem_arbiter.sv
      - source/data_ram.sv
      - source/soc_top.sv
  - target: test
    files:
      - dv/soc_top_tb.sv

//--- dv/soc_top_tb.sv
`timescale 1ns/1ps
//==========================================================================
// soc_top testbench: UART host, switch stimulus, model RAM and checks
//==========================================================================

module soc_top_tb
  import soc_pkg::*;
();

  // response wait, in clocks, covers a full three-byte command
  localparam int    RSP_TIMEOUT = 4000;
  localparam int    LED_TIMEOUT = 200;
  localparam byte_t BAD_CMD     = 8'h5A;
  // two whole frames, then start and data bits, then into the stop bit
  localparam int    SW_SKEW     = 2 * 10 * CLKS_PER_BIT + 9 * CLKS_PER_BIT + 10;

  logic  clk;
  logic  i_arst_n;
  logic  i_uart_rx;
  sw_t   i_sw;
  logic  o_uart_tx;
  byte_t o_led;

  integer seed;
  int     errors;
  int     tests_passed;
  int     tests_failed;
  int     test_err_base;
  // switch events logged so far
  int     events;
  logic   idle_check;
  // expected RAM contents
  byte_t  model_mem [RAM_DEPTH];

  soc_top dut (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_uart_rx (i_uart_rx),
    .o_uart_tx (o_uart_tx),
    .i_sw      (i_sw),
    .o_led     (o_led)
  );

  always #10 clk = ~clk;

  // ==========================================================================
  // concurrent checks
  // ==========================================================================
  // quiet outputs between reset and first stimulus
  a_idle_quiet: assert property (
    @(posedge clk) disable iff (!i_arst_n) idle_check |-> o_uart_tx && (o_led == '0)
  ) else begin
    errors++;
    $display("MISMATCH at %0t: o_uart_tx/o_led expected 1/00 got %b/%h",
             $time, o_uart_tx, o_led);
  end

  // led count only ever steps by one
  a_led_steps: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (o_led != $past(o_led)) |-> (o_led == byte_t'($past(o_led) + 8'd1))
  ) else begin
    errors++;
    $display("MISMATCH at %0t: o_led expected %h got %h",
             $time, byte_t'($past(o_led) + 8'd1), o_led);
  end

  // ==========================================================================
  // helpers
  // ==========================================================================
  task automatic check_byte(input string name, input byte_t exp, input byte_t got);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_base) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  // one 8N1 frame, caller sits on a falling edge
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      i_uart_rx = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  // wait for a start bit, then sample mid-bit
  task automatic recv_byte(output byte_t b);
    int wait_cnt;
    int i;
    b        = '0;
    wait_cnt = 0;
    while (o_uart_tx && wait_cnt < RSP_TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (o_uart_tx) begin
      errors++;
      $display("timeout at %0t: no response start bit on o_uart_tx", $time);
    end else begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        b[i] = o_uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (!o_uart_tx) begin
        errors++;
        $display("framing error at %0t: response stop bit is low", $time);
      end
    end
  endtask

  // response may start inside the last stop bit, so rx runs alongside
  task automatic host_cmd(input byte_t b0, input byte_t b1, input byte_t b2,
                          input int nbytes, output byte_t rsp);
    @(negedge clk);
    fork
      begin
        send_byte(b0);
        if (nbytes > 1) begin
          send_byte(b1);
        end
        if (nbytes > 2) begin
          send_byte(b2);
        end
      end
      recv_byte(rsp);
    join
  endtask

  task automatic host_write(input addr_t a, input byte_t d, output byte_t rsp);
    host_cmd(CMD_WRITE, a, d, 3, rsp);
  endtask

  task automatic host_read(input addr_t a, output byte_t d);
    host_cmd(CMD_READ, a, 8'h00, 2, d);
  endtask

  // read one byte back and compare with the model
  task automatic read_check(input addr_t a);
    byte_t d;
    host_read(a, d);
    check_byte($sformatf("ram[%h]", a), model_mem[a], d);
  endtask

  // random switch value, always a real change
  task automatic next_switch(output sw_t v);
    v = sw_t'($random(seed));
    if (v == i_sw) begin
      v = ~v;
    end
  endtask

  // record byte is seq nibble over switch value
  task automatic apply_switch(input sw_t v);
    i_sw = v;
    model_mem[LOG_BASE + addr_t'(events % LOG_DEPTH)] = {events[3:0], v};
    events++;
  endtask

  task automatic wait_led();
    int wait_cnt;
    wait_cnt = 0;
    while (o_led != byte_t'(events) && wait_cnt < LED_TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (o_led != byte_t'(events)) begin
      errors++;
      $display("timeout at %0t: o_led did not reach event count %0d", $time, events);
    end
    check_byte("o_led", byte_t'(events), o_led);
  endtask

  // one change, spaced far from the next
  task automatic switch_event();
    sw_t v;
    next_switch(v);
    @(negedge clk);
    apply_switch(v);
    wait_led();
    repeat (20) @(negedge clk);
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    addr_t a;
    byte_t d;
    byte_t rsp;
    sw_t   v;
    int    n;
    clk           = 1'b0;
    i_arst_n      = 1'b0;
    i_uart_rx     = 1'b1;
    i_sw          = '0;
    seed          = 32'hfd3bb58c;
    errors        = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    test_err_base = 0;
    events        = 0;
    idle_check    = 1'b0;
    a             = '0;

    repeat (8) @(negedge clk);
    i_arst_n   = 1'b1;
    idle_check = 1'b1;

    // quiet after reset
    repeat (50) @(negedge clk);
    check_byte("o_uart_tx", 8'h01, {7'h0, o_uart_tx});
    check_byte("o_led", 8'h00, o_led);
    idle_check = 1'b0;
    end_test("reset idle");

    // random write and read back below the log ring
    for (n = 0; n < 20; n++) begin
      a = addr_t'({$random(seed)} % LOG_BASE);
      d = byte_t'($random(seed));
      host_write(a, d, rsp);
      check_byte("write response", RSP_ACK, rsp);
      model_mem[a] = d;
      read_check(a);
    end
    end_test("write read");

    // unknown command answers at once, memory untouched
    host_cmd(BAD_CMD, 8'h00, 8'h00, 1, rsp);
    check_byte("error response", RSP_ERR, rsp);
    read_check(a);
    end_test("unknown command");

    // switch log records
    for (n = 0; n < 5; n++) begin
      switch_event();
    end
    for (n = 0; n < 5; n++) begin
      read_check(LOG_BASE + addr_t'(n));
    end
    end_test("switch log");

    // switch change meets the bridge request on the bus
    a = addr_t'({$random(seed)} % LOG_BASE);
    d = byte_t'($random(seed));
    next_switch(v);
    @(negedge clk);
    fork
      host_write(a, d, rsp);
      begin
        repeat (SW_SKEW) @(negedge clk);
        apply_switch(v);
      end
    join
    check_byte("write response", RSP_ACK, rsp);
    model_mem[a] = d;
    wait_led();
    read_check(a);
    read_check(LOG_BASE + addr_t'((events - 1) % LOG_DEPTH));
    end_test("contention");

    // ring wrap, event 16 lands on slot 0
    while (events < LOG_DEPTH + 1) begin
      switch_event();
    end
    host_read(LOG_BASE, rsp);
    check_byte("ram[f0]", model_mem[LOG_BASE], rsp);
    check_byte("log seq nibble", 8'h00, {4'h0, rsp[7:4]});
    end_test("ring wrap");

    $display("tests: %0d passed, %0d failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ps
//==========================================================================
// single-port byte RAM, synchronous write, registered read
//==========================================================================

module data_ram
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  i_en,
  input  logic  i_we,
  input  addr_t i_addr,
  input  byte_t i_wdata,
  output byte_t o_rdata
);

  // storage array
  byte_t mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (i_en) begin
      if (i_we) begin
        mem[i_addr] <= i_wdata;
      end
      // read-first, one cycle latency
      o_rdata <= mem[i_addr];
    end
  end

endmodule

//--- source/dbg_bridge.sv
`timescale 1ns/1ps
//==========================================================================
// debug bridge parsing host UART commands into RAM reads and writes
//==========================================================================

module dbg_bridge
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  byte_t i_rx_data,
  input  logic  i_rx_valid,
  output byte_t o_tx_data,
  output logic  o_tx_start,
  input  logic  i_tx_busy,
  output logic  o_req,
  output logic  o_we,
  output addr_t o_addr,
  output byte_t o_wdata,
  input  logic  i_gnt,
  input  logic  i_rvalid,
  input  byte_t i_rdata
);

  typedef enum logic [2:0] {
    BR_CMD,
    BR_ADDR,
    BR_DATA,
    BR_BUS,
    BR_RDATA,
    BR_RESP
  } br_state_t;

  br_state_t state;
  logic      is_write;
  logic      cmd_known;
  addr_t     addr;
  byte_t     wdata;
  byte_t     rsp;

  assign cmd_known = (i_rx_data == CMD_WRITE) || (i_rx_data == CMD_READ);

  // bus request held for the whole BR_BUS state
  assign o_req   = (state == BR_BUS);
  assign o_we    = is_write;
  assign o_addr  = addr;
  assign o_wdata = wdata;

  // response goes out as soon as the transmitter is free
  assign o_tx_data  = rsp;
  assign o_tx_start = (state == BR_RESP) && !i_tx_busy;

  // ==========================================================================
  // command FSM
  // ==========================================================================
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= BR_CMD;
      is_write <= 1'b0;
    end else begin
      case (state)
        BR_CMD: begin
          if (i_rx_valid) begin
            is_write <= (i_rx_data == CMD_WRITE);
            // unknown byte answers at once
            state    <= cmd_known ? BR_ADDR : BR_RESP;
          end
        end
        BR_ADDR: begin
          if (i_rx_valid) begin
            state <= is_write ? BR_DATA : BR_BUS;
          end
        end
        BR_DATA: begin
          if (i_rx_valid) begin
            state <= BR_BUS;
          end
        end
        BR_BUS: begin
          // gnt cycle is the transfer
          if (i_gnt) begin
            state <= is_write ? BR_RESP : BR_RDATA;
          end
        end
        BR_RDATA: begin
          if (i_rvalid) begin
            state <= BR_RESP;
          end
        end
        BR_RESP: begin
          // rx bytes up to here are ignored
          if (!i_tx_busy) begin
            state <= BR_CMD;
          end
        end
        default: state <= BR_CMD;
      endcase
    end
  end

  // address, data and response bytes
  always_ff @(posedge clk) begin
    if (state == BR_ADDR && i_rx_valid) begin
      addr <= i_rx_data;
    end
    if (state == BR_DATA && i_rx_valid) begin
      wdata <= i_rx_data;
    end
    if (state == BR_CMD && i_rx_valid && !cmd_known) begin
      rsp <= RSP_ERR;
    end else if (state == BR_BUS && i_gnt && is_write) begin
      rsp <= RSP_ACK;
    end else if (state == BR_RDATA && i_rvalid) begin
      rsp <= i_rdata;
    end
  end

endmodule

//--- source/mem_arbiter.sv
`timescale 1ns/1ps
//==========================================================================
// round-robin arbiter placing two bus masters onto one RAM port
//==========================================================================

module mem_arbiter
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_m0_req,
  input  logic  i_m0_we,
  input  addr_t i_m0_addr,
  input  byte_t i_m0_wdata,
  output logic  o_m0_gnt,
  output logic  o_m0_rvalid,
  input  logic  i_m1_req,
  input  logic  i_m1_we,
  input  addr_t i_m1_addr,
  input  byte_t i_m1_wdata,
  output logic  o_m1_gnt,
  output logic  o_m1_rvalid,
  output byte_t o_rdata,
  output logic  o_ram_en,
  output logic  o_ram_we,
  output addr_t o_ram_addr,
  output byte_t o_ram_wdata,
  input  byte_t i_ram_rdata
);

  logic last_m1;
  logic rd_pending;
  logic rd_owner;

  // on a tie the master not granted last wins
  assign o_m0_gnt = i_m0_req && (!i_m1_req || last_m1);
  assign o_m1_gnt = i_m1_req && (!i_m0_req || !last_m1);

  // RAM command straight from the winner
  assign o_ram_en    = o_m0_gnt || o_m1_gnt;
  assign o_ram_we    = o_ram_en && (o_m1_gnt ? i_m1_we : i_m0_we);
  assign o_ram_addr  = o_m1_gnt ? i_m1_addr : i_m0_addr;
  assign o_ram_wdata = o_m1_gnt ? i_m1_wdata : i_m0_wdata;

  // read data comes one cycle later and is routed by owner
  assign o_rdata     = i_ram_rdata;
  assign o_m0_rvalid = rd_pending && !rd_owner;
  assign o_m1_rvalid = rd_pending && rd_owner;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      last_m1    <= 1'b0;
      rd_pending <= 1'b0;
      rd_owner   <= 1'b0;
    end else begin
      rd_pending <= o_ram_en && !o_ram_we;
      if (o_ram_en) begin
        last_m1  <= o_m1_gnt;
        rd_owner <= o_m1_gnt;
      end
    end
  end

  a_gnt_onehot: assert property (
    @(posedge clk) disable iff (!i_arst_n) !(o_m0_gnt && o_m1_gnt)
  );

  a_gnt_has_req: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (o_m0_gnt |-> i_m0_req) and (o_m1_gnt |-> i_m1_req)
  );

endmodule

//--- source/soc_pkg.sv
//==========================================================================
// soc package: shared widths, UART timing, debug command codes, memory map
//==========================================================================

package soc_pkg;

  // ==========================================================================
  // data widths
  // ==========================================================================
  // one data byte on UART and bus
  typedef logic [7:0] byte_t;
  // RAM byte address
  typedef logic [7:0] addr_t;
  // DIP switch vector
  typedef logic [3:0] sw_t;

  // number of RAM bytes, whole address space
  localparam int RAM_DEPTH = 2 ** $bits(addr_t);

  // ==========================================================================
  // UART timing
  // ==========================================================================
  // clocks per bit, kept short for simulation
  localparam int CLKS_PER_BIT = 16;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
  typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;
  // end of a full bit period
  localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
  // middle of the start bit
  localparam baud_cnt_t BAUD_HALF = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

  // ==========================================================================
  // debug command set
  // ==========================================================================
  localparam byte_t CMD_WRITE = 8'h57;
  localparam byte_t CMD_READ  = 8'h52;
  localparam byte_t RSP_ACK   = 8'h4B;
  localparam byte_t RSP_ERR   = 8'h3F;

  // ==========================================================================
  // switch log ring at the top of RAM
  // ==========================================================================
  localparam addr_t LOG_BASE  = 8'hF0;
  localparam int    LOG_DEPTH = 16;
  localparam int    LOG_PTR_W = $clog2(LOG_DEPTH);
  typedef logic [LOG_PTR_W-1:0] log_ptr_t;
  localparam log_ptr_t LOG_PTR_LAST = log_ptr_t'(LOG_DEPTH - 1);

endpackage

//--- source/soc_top.sv
`timescale 1ns/1ps
//==========================================================================
// SoC top: UART debug bridge and switch logger sharing one byte RAM
//==========================================================================

module soc_top
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_uart_rx,
  output logic  o_uart_tx,
  input  sw_t   i_sw,
  output byte_t o_led
);

  // ==========================================================================
  // UART side
  // ==========================================================================
  byte_t rx_data;
  logic  rx_valid;
  byte_t tx_data;
  logic  tx_start;
  logic  tx_busy;

  // bridge bus, master 0
  logic  m0_req;
  logic  m0_we;
  addr_t m0_addr;
  byte_t m0_wdata;
  logic  m0_gnt;
  logic  m0_rvalid;

  // logger bus, master 1
  logic  m1_req;
  logic  m1_we;
  addr_t m1_addr;
  byte_t m1_wdata;
  logic  m1_gnt;

  // shared read data and RAM port
  byte_t bus_rdata;
  logic  ram_en;
  logic  ram_we;
  addr_t ram_addr;
  byte_t ram_wdata;
  byte_t ram_rdata;

  uart_rx u_uart_rx (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_rx     (i_uart_rx),
    .o_data   (rx_data),
    .o_valid  (rx_valid)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_start  (tx_start),
    .i_data   (tx_data),
    .o_tx     (o_uart_tx),
    .o_busy   (tx_busy)
  );

  dbg_bridge u_dbg_bridge (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_rx_data  (rx_data),
    .i_rx_valid (rx_valid),
    .o_tx_data  (tx_data),
    .o_tx_start (tx_start),
    .i_tx_busy  (tx_busy),
    .o_req      (m0_req),
    .o_we       (m0_we),
    .o_addr     (m0_addr),
    .o_wdata    (m0_wdata),
    .i_gnt      (m0_gnt),
    .i_rvalid   (m0_rvalid),
    .i_rdata    (bus_rdata)
  );

  // logger only writes, its rvalid is left open
  switch_logger u_switch_logger (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_sw     (i_sw),
    .o_led    (o_led),
    .o_req    (m1_req),
    .o_we     (m1_we),
    .o_addr   (m1_addr),
    .o_wdata  (m1_wdata),
    .i_gnt    (m1_gnt)
  );

  mem_arbiter u_mem_arbiter (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_m0_req    (m0_req),
    .i_m0_we     (m0_we),
    .i_m0_addr   (m0_addr),
    .i_m0_wdata  (m0_wdata),
    .o_m0_gnt    (m0_gnt),
    .o_m0_rvalid (m0_rvalid),
    .i_m1_req    (m1_req),
    .i_m1_we     (m1_we),
    .i_m1_addr   (m1_addr),
    .i_m1_wdata  (m1_wdata),
    .o_m1_gnt    (m1_gnt),
    .o_m1_rvalid (),
    .o_rdata     (bus_rdata),
    .o_ram_en    (ram_en),
    .o_ram_we    (ram_we),
    .o_ram_addr  (ram_addr),
    .o_ram_wdata (ram_wdata),
    .i_ram_rdata (ram_rdata)
  );

  data_ram u_data_ram (
    .clk     (clk),
    .i_en    (ram_en),
    .i_we    (ram_we),
    .i_addr  (ram_addr),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

endmodule

//--- source/switch_logger.sv
`timescale 1ns/1ps
//==========================================================================
// switch logger: records each DIP switch change into a RAM ring
//==========================================================================

module switch_logger
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  sw_t   i_sw,
  output byte_t o_led,
  output logic  o_req,
  output logic  o_we,
  output addr_t o_addr,
  output byte_t o_wdata,
  input  logic  i_gnt
);

  sw_t      sw_meta;
  sw_t      sw_sync;
  sw_t      last_sw;
  sw_t      rec_sw;
  logic     loaded;
  logic     pend;
  logic     start_log;
  log_ptr_t ptr;
  byte_t    count;

  // new change only while no write is pending
  assign start_log = loaded && !pend && (sw_sync != last_sw);

  assign o_req   = pend;
  // logger only ever writes
  assign o_we    = 1'b1;
  assign o_addr  = LOG_BASE + addr_t'(ptr);
  // seq nibble on top, switches below
  assign o_wdata = {count[3:0], rec_sw};
  assign o_led   = count;

  // two-flop sync, settles while reset is held
  always_ff @(posedge clk) begin
    sw_meta <= i_sw;
    sw_sync <= sw_meta;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      loaded  <= 1'b0;
      pend    <= 1'b0;
      last_sw <= '0;
      ptr     <= '0;
      count   <= '0;
    end else begin
      if (!loaded) begin
        // switches set at reset are not events
        loaded  <= 1'b1;
        last_sw <= sw_sync;
      end else if (pend) begin
        if (i_gnt) begin
          pend    <= 1'b0;
          last_sw <= rec_sw;
          ptr     <= (ptr == LOG_PTR_LAST) ? '0 : ptr + 1'b1;
          count   <= count + 1'b1;
        end
      end else if (start_log) begin
        pend <= 1'b1;
      end
    end
  end

  // value captured at request, later changes compare next time
  always_ff @(posedge clk) begin
    if (start_log) begin
      rec_sw <= sw_sync;
    end
  end

endmodule

//--- source/uart_rx.sv
`timescale 1ns/1ps
//==========================================================================
// UART receiver, 8N1, mid-bit sampling, one-cycle strobe per byte
//==========================================================================

module uart_rx
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_rx,
  output byte_t o_data,
  output logic  o_valid
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t  state;
  logic       rx_meta;
  logic       rx_sync;
  baud_cnt_t  baud_cnt;
  logic [2:0] bit_idx;
  byte_t      shift;
  logic       baud_done;

  assign baud_done = (baud_cnt == BAUD_LAST);
  // byte stays put from stop bit to next frame
  assign o_data = shift;

  // two-flop sync, idle level is high
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      o_valid  <= 1'b0;
    end else begin
      o_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          // falling edge of start bit
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (baud_cnt == BAUD_HALF) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            // glitch shorter than half a bit, back to idle
            state    <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (baud_done) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (baud_done) begin
            state   <= RX_IDLE;
            // low stop bit drops the byte
            o_valid <= rx_sync;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && baud_done) begin
      shift <= {rx_sync, shift[7:1]};
    end
  end

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ps
//==========================================================================
// UART transmitter, 8N1, busy level held over the whole frame
//==========================================================================

module uart_tx
  import soc_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_start,
  input  byte_t i_data,
  output logic  o_tx,
  output logic  o_busy
);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t  state;
  baud_cnt_t  baud_cnt;
  logic [2:0] bit_idx;
  byte_t      shift;
  logic       baud_done;

  assign baud_done = (baud_cnt == BAUD_LAST);
  assign o_busy    = (state != TX_IDLE);

  // line level from registered state, idle and stop are high
  assign o_tx = (state == TX_START) ? 1'b0 :
                (state == TX_DATA)  ? shift[0] : 1'b1;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          if (i_start) begin
            state <= TX_START;
          end
        end
        TX_START: begin
          if (baud_done) begin
            baud_cnt <= '0;
            state    <= TX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (baud_done) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= TX_STOP;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          // frame ends after 10 bit times
          if (baud_done) begin
            state <= TX_IDLE;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // load on start, shift out lsb first
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && i_start) begin
      shift <= i_data;
    end else if (state == TX_DATA && baud_done) begin
      shift <= {1'b1, shift[7:1]};
    end
  end

  // the bridge must wait for the frame to finish
  a_no_start_when_busy: assert property (
    @(posedge clk) disable iff (!i_arst_n) o_busy |-> !i_start
  );

endmodule

//--- verilog.f
source/soc_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/dbg_bridge.sv
source/switch_logger.sv
source/mem_arbiter.sv
source/data_ram.sv
source/soc_top.sv
dv/soc_top_tb.sv
